// ==== design/boot_pkg.sv ====
package boot_pkg;

  // One instruction or data word as stored in the ICCM
  typedef logic [31:0] word_t;

  // Upper half of a valid load header
  localparam logic [15:0] BOOT_MAGIC = 16'hB007;

  // Assembled word with two views
  // Header view splits it into magic and word count
  typedef union packed {
    word_t raw;
    struct packed {
      logic [15:0] magic;
      logic [15:0] count;
    } hdr;
  } load_word_u;

  // One received character from the serial line
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_beat_t;

  // Loader write strobe into the ICCM
  typedef struct packed {
    logic        we;
    logic [15:0] addr;
    word_t       data;
  } iccm_wr_t;

  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_SLVERR = 2'b10
  } axi_resp_e;

  // AXI4-Lite read address channel
  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
  } axi_ar_t;

  // AXI4-Lite read data channel
  typedef struct packed {
    logic      rvalid;
    word_t     rdata;
    axi_resp_e rresp;
  } axi_r_t;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               rx_i,
  output boot_pkg::rx_beat_t beat_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  // Start bit is checked half a bit period after the falling edge
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e        state_q;
  logic             sync1_q;
  logic             sync2_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic [7:0]       data_q;
  logic             valid_q;
  logic             bit_mid;

  assign bit_mid = (cnt_q == CNT_LAST);

  // Line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b1;
      sync2_q <= 1'b1;
    end else begin
      sync1_q <= rx_i;
      sync2_q <= sync1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!sync2_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (cnt_q == CNT_HALF) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // High at mid start means a glitch
            state_q   <= sync2_q ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_mid) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 3'd1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (bit_mid) begin
            cnt_q   <= '0;
            state_q <= RX_IDLE;
            // Framing error drops the byte silently
            valid_q <= sync2_q;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first on the wire
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && bit_mid) begin
      shift_q <= {sync2_q, shift_q[7:1]};
    end
    if (state_q == RX_STOP && bit_mid) begin
      data_q <= shift_q;
    end
  end

  assign beat_o.valid = valid_q;
  assign beat_o.data  = data_q;

endmodule

// ==== design/iccm_loader.sv ====
`timescale 1ns/1ps

module iccm_loader #(
  parameter int MEM_DEPTH_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  boot_pkg::rx_beat_t beat_i,
  output boot_pkg::iccm_wr_t wr_o,
  output logic               boot_done_o,
  output logic               load_err_o
);

  import boot_pkg::*;

  typedef enum logic [1:0] {
    LD_HDR,
    LD_PAYLOAD,
    LD_DONE
  } ld_state_e;

  ld_state_e   state_q;
  word_t       word_q;
  logic [1:0]  byte_cnt_q;
  logic [15:0] count_q;
  logic [15:0] addr_q;
  logic        wr_we_q;
  logic [15:0] wr_addr_q;
  word_t       wr_data_q;
  logic        done_q;
  logic        err_q;
  load_word_u  next_word;
  logic        take_byte;
  logic        word_end;
  logic        hdr_ok;

  // Bytes are dropped once the load is complete
  assign take_byte = beat_i.valid && (state_q != LD_DONE);
  assign word_end  = take_byte && (byte_cnt_q == 2'd3);

  // Little-endian so the newest byte lands in the top lane
  assign next_word.raw = {beat_i.data, word_q[31:8]};

  assign hdr_ok = (next_word.hdr.magic == BOOT_MAGIC) &&
                  (next_word.hdr.count != 16'd0) &&
                  (32'(next_word.hdr.count) <= MEM_DEPTH_WORDS);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= LD_HDR;
      byte_cnt_q <= '0;
      count_q    <= '0;
      addr_q     <= '0;
      wr_we_q    <= 1'b0;
      done_q     <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      wr_we_q <= 1'b0;
      // Trails the last strobe by one cycle
      done_q  <= (state_q == LD_DONE);
      if (take_byte) begin
        byte_cnt_q <= byte_cnt_q + 2'd1;
      end
      if (word_end) begin
        case (state_q)
          LD_HDR: begin
            if (hdr_ok) begin
              count_q <= next_word.hdr.count;
              addr_q  <= '0;
              state_q <= LD_PAYLOAD;
            end else begin
              // Sticky, wait for another header
              err_q <= 1'b1;
            end
          end
          LD_PAYLOAD: begin
            wr_we_q <= 1'b1;
            addr_q  <= addr_q + 16'd1;
            if (addr_q + 16'd1 == count_q) begin
              state_q <= LD_DONE;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_byte) begin
      word_q <= next_word.raw;
    end
    if (word_end) begin
      wr_addr_q <= addr_q;
      wr_data_q <= next_word.raw;
    end
  end

  assign wr_o.we   = wr_we_q;
  assign wr_o.addr = wr_addr_q;
  assign wr_o.data = wr_data_q;

  assign boot_done_o = done_q;
  assign load_err_o  = err_q;

endmodule

// ==== design/iccm_mem.sv ====
`timescale 1ns/1ps

module iccm_mem #(
  parameter int MEM_DEPTH_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  boot_pkg::iccm_wr_t wr_i,
  input  logic               boot_done_i,
  input  boot_pkg::axi_ar_t  ar_i,
  output logic               arready_o,
  output boot_pkg::axi_r_t   r_o,
  input  logic               rready_i
);

  import boot_pkg::*;

  localparam int IDX_W = (MEM_DEPTH_WORDS > 1) ? $clog2(MEM_DEPTH_WORDS) : 1;

  word_t            mem_q [MEM_DEPTH_WORDS];
  logic             rvalid_q;
  word_t            rdata_q;
  axi_resp_e        rresp_q;
  logic             ar_hs;
  logic             rd_ok;
  logic [IDX_W-1:0] rd_idx;

  // Single response slot so a pending beat blocks the address channel
  assign arready_o = !rvalid_q;
  assign ar_hs     = ar_i.arvalid && arready_o;

  assign rd_idx = ar_i.araddr[IDX_W+1:2];
  // Aligned and in range after the boot image is in place
  assign rd_ok  = boot_done_i &&
                  (ar_i.araddr[1:0] == 2'b00) &&
                  ({2'b00, ar_i.araddr[31:2]} < 32'(MEM_DEPTH_WORDS));

  // Loader write port
  always_ff @(posedge clk_i) begin
    if (wr_i.we) begin
      mem_q[wr_i.addr[IDX_W-1:0]] <= wr_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // Captured at the handshake, held through rready stalls
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rd_ok ? mem_q[rd_idx] : '0;
      rresp_q <= rd_ok ? AXI_OKAY : AXI_SLVERR;
    end
  end

  assign r_o.rvalid = rvalid_q;
  assign r_o.rdata  = rdata_q;
  assign r_o.rresp  = rresp_q;

endmodule

// ==== design/uart_boot_top.sv ====
`timescale 1ns/1ps

module uart_boot_top #(
  parameter int CLKS_PER_BIT    = 868,
  parameter int MEM_DEPTH_WORDS = 1024
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              uart_rx_i,
  input  boot_pkg::axi_ar_t ar_i,
  output logic              arready_o,
  output boot_pkg::axi_r_t  r_o,
  input  logic              rready_i,
  output logic              boot_done_o,
  output logic              load_err_o
);

  import boot_pkg::*;

  rx_beat_t rx_beat;
  iccm_wr_t iccm_wr;

  // Serial line to byte beats
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rx_i    (uart_rx_i),
    .beat_o  (rx_beat)
  );

  // Header check and word writes
  iccm_loader #(
    .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
  ) u_iccm_loader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .beat_i      (rx_beat),
    .wr_o        (iccm_wr),
    .boot_done_o (boot_done_o),
    .load_err_o  (load_err_o)
  );

  iccm_mem #(
    .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
  ) u_iccm_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_i        (iccm_wr),
    .boot_done_i (boot_done_o),
    .ar_i        (ar_i),
    .arready_o   (arready_o),
    .r_o         (r_o),
    .rready_i    (rready_i)
  );

endmodule

// ==== dv/uart_boot_props.sv ====
`timescale 1ns/1ps

module uart_boot_props (
  input logic              clk_i,
  input logic              rst_n_i,
  input boot_pkg::axi_ar_t ar_i,
  input logic              arready_i,
  input boot_pkg::axi_r_t  r_i,
  input logic              rready_i,
  input logic              boot_done_i
);

  // Address must hold until accepted
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_i.arvalid && !arready_i |=> ar_i.arvalid && $stable(ar_i.araddr))
    else $error("arvalid or araddr changed before arready");

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_i.rvalid && !rready_i |=> r_i.rvalid && $stable(r_i.rdata) && $stable(r_i.rresp))
    else $error("R beat changed before rready");

  // R beat one cycle after the address handshake
  r_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_i.arvalid && arready_i |=> r_i.rvalid)
    else $error("no R beat one cycle after the address handshake");

  done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    boot_done_i |=> boot_done_i)
    else $error("boot_done fell while out of reset");

endmodule

bind iccm_mem uart_boot_props u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .ar_i        (ar_i),
  .arready_i   (arready_o),
  .r_i         (r_o),
  .rready_i    (rready_i),
  .boot_done_i (boot_done_i)
);

// ==== dv/uart_boot_tb.sv ====
`timescale 1ns/1ps

module uart_boot_tb;

  import boot_pkg::*;

  localparam int CLKS_PER_BIT    = 8;
  localparam int MEM_DEPTH_WORDS = 64;
  // Bad header and 20-word frame, then bad header and a full-depth frame
  localparam int FRAME_BYTES     = 4 + 4 * 21 + 4 + 4 * (MEM_DEPTH_WORDS + 1);
  localparam int FRAME_BITS      = FRAME_BYTES * 10;
  localparam int NUM_READS       = 25;
  localparam int READ_CYCLES     = NUM_READS * 16;
  localparam int TIMEOUT_CYCLES  = 2 * FRAME_BITS * CLKS_PER_BIT + READ_CYCLES;

  typedef struct packed {
    word_t     data;
    axi_resp_e resp;
  } rd_exp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        done;
  } rd_req_t;

  logic        clk;
  logic        rst_n;
  logic        uart_rx;
  axi_ar_t     ar;
  logic        arready;
  axi_r_t      r;
  logic        rready;
  logic        boot_done;
  logic        load_err;
  word_t       frame_words [MEM_DEPTH_WORDS];
  word_t       model_mem [MEM_DEPTH_WORDS];
  logic        model_done;
  rd_req_t     pending_q [$];
  logic [31:0] rng_state = 32'h6d82;
  string       cur_test = "reset state";
  int          cycle_cnt;

  uart_boot_top #(
    .CLKS_PER_BIT    (CLKS_PER_BIT),
    .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
  ) dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .uart_rx_i   (uart_rx),
    .ar_i        (ar),
    .arready_o   (arready),
    .r_o         (r),
    .rready_i    (rready),
    .boot_done_o (boot_done),
    .load_err_o  (load_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // OKAY only for an aligned in-range word once the image is loaded
  function automatic rd_exp_t expected_read(input logic [31:0] addr, input logic done,
                                            input word_t model [MEM_DEPTH_WORDS]);
    rd_exp_t res;
    res.data = '0;
    res.resp = AXI_SLVERR;
    if (done && (addr % 4 == 0) && (addr / 4 < MEM_DEPTH_WORDS)) begin
      res.data = model[addr / 4];
      res.resp = AXI_OKAY;
    end
    return res;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected %08h, actual %08h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e expected,
                            input axi_resp_e actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected %s, actual %b",
                                  name, expected.name(), actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected %b, actual %b",
                                  name, expected, actual));
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Called 1 ns after an edge, returns at the same phase
  task automatic send_bit(input logic b);
    uart_rx = b;
    repeat (CLKS_PER_BIT) @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input logic [7:0] b);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      send_bit(b[i]);
    end
    send_bit(1'b1);
  endtask

  task automatic send_word(input word_t w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  task automatic send_frame(input logic [15:0] magic, input logic [15:0] count,
                            input int nwords);
    send_word({magic, count});
    for (int i = 0; i < nwords; i++) begin
      send_word(frame_words[i]);
    end
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      frame_words[i] = next_random();
    end
  endtask

  task automatic load_model(input int n);
    for (int i = 0; i < n; i++) begin
      model_mem[i] = frame_words[i];
    end
  endtask

  task automatic wait_for_err();
    while (!load_err) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_for_done();
    while (!boot_done) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Holds rready low for a random stall, then takes the pending R beat
  task automatic complete_r_beat();
    int stall;
    stall = int'(next_random() % 6);
    repeat (stall) begin
      @(posedge clk);
      #1;
    end
    rready = 1'b1;
    while (!r.rvalid) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // Address goes out while the previous beat may still be stalled
  task automatic axi_read(input logic [31:0] addr);
    rd_req_t req;
    ar.arvalid = 1'b1;
    ar.araddr  = addr;
    if (r.rvalid) begin
      complete_r_beat();
    end
    while (!arready) begin
      @(posedge clk);
      #1;
    end
    // Address is taken on the coming edge
    req.addr = addr;
    req.done = model_done;
    pending_q.push_back(req);
    @(posedge clk);
    #1;
    ar.arvalid = 1'b0;
  endtask

  // R beats are checked half a cycle before their handshake edge
  always @(negedge clk) begin : compare_r
    rd_req_t req;
    rd_exp_t exp_rd;
    if (rst_n && r.rvalid && rready) begin
      if (pending_q.size() == 0) begin
        stop_with_failure("An R beat arrived with no read outstanding");
      end else begin
        req    = pending_q.pop_front();
        exp_rd = expected_read(req.addr, req.done, model_mem);
        check_word(cur_test, exp_rd.data, r.rdata);
        check_resp(cur_test, exp_rd.resp, r.rresp);
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    stop_with_failure($sformatf("Timeout after %0d cycles, the load never finished",
                                cycle_cnt));
  end

  initial begin
    uart_rx    = 1'b1;
    ar         = '0;
    rready     = 1'b0;
    rst_n      = 1'b0;
    model_done = 1'b0;
    for (int i = 0; i < MEM_DEPTH_WORDS; i++) begin
      model_mem[i] = '0;
    end
    apply_reset();

    check_flag(cur_test, 1'b0, boot_done);
    check_flag(cur_test, 1'b0, load_err);
    axi_read(32'h0);
    complete_r_beat();

    cur_test = "bad magic";
    send_frame(16'hBAD0, 16'd20, 0);
    wait_for_err();
    check_flag(cur_test, 1'b0, boot_done);

    cur_test = "good frame";
    fill_random(20);
    send_frame(BOOT_MAGIC, 16'd20, 20);
    wait_for_done();
    load_model(20);
    model_done = 1'b1;
    check_flag(cur_test, 1'b1, load_err);

    cur_test = "loaded reads";
    for (int i = 0; i < 20; i++) begin
      axi_read(32'(i * 4));
    end
    complete_r_beat();

    cur_test = "bad address";
    axi_read(32'h2);
    axi_read(32'(MEM_DEPTH_WORDS * 4));
    complete_r_beat();

    cur_test = "second reset";
    model_done = 1'b0;
    apply_reset();
    check_flag(cur_test, 1'b0, boot_done);
    check_flag(cur_test, 1'b0, load_err);

    cur_test = "count too large";
    send_frame(BOOT_MAGIC, 16'(MEM_DEPTH_WORDS + 1), 0);
    wait_for_err();
    check_flag(cur_test, 1'b0, boot_done);

    cur_test = "full memory";
    fill_random(MEM_DEPTH_WORDS);
    send_frame(BOOT_MAGIC, 16'(MEM_DEPTH_WORDS), MEM_DEPTH_WORDS);
    wait_for_done();
    load_model(MEM_DEPTH_WORDS);
    model_done = 1'b1;
    check_flag(cur_test, 1'b1, load_err);
    axi_read(32'h0);
    axi_read(32'((MEM_DEPTH_WORDS - 1) * 4));
    complete_r_beat();

    if (pending_q.size() != 0) begin
      stop_with_failure("A read request was left without an R beat");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== uart_boot_top.f ====
design/boot_pkg.sv
design/uart_rx.sv
design/iccm_loader.sv
design/iccm_mem.sv
design/uart_boot_top.sv
dv/uart_boot_props.sv
dv/uart_boot_tb.sv

// ==== Makefile ====
TOP := uart_boot_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f uart_boot_top.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
